// ==== rtl/dhcp_pkg.sv ====
package dhcp_pkg;

  // ----------------------------------------------------------
  // client states
  // ----------------------------------------------------------
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_DISCOVER,    // discover queued or on the wire
    ST_WAIT_OFFER,
    ST_REQUEST,     // request queued or on the wire
    ST_WAIT_ACK,
    ST_BOUND,
    ST_FAILED
  } dhcp_state_t;

  // option 53 values
  localparam logic [7:0] MSG_DISCOVER = 8'd1;
  localparam logic [7:0] MSG_OFFER    = 8'd2;
  localparam logic [7:0] MSG_REQUEST  = 8'd3;
  localparam logic [7:0] MSG_ACK      = 8'd5;
  localparam logic [7:0] MSG_NAK      = 8'd6;

  // option codes
  localparam logic [7:0] OPT_PAD       = 8'd0;
  localparam logic [7:0] OPT_REQ_IP    = 8'd50;
  localparam logic [7:0] OPT_LEASE     = 8'd51;
  localparam logic [7:0] OPT_MSG_TYPE  = 8'd53;
  localparam logic [7:0] OPT_SERVER_ID = 8'd54;
  localparam logic [7:0] OPT_END       = 8'd255;

  // ----------------------------------------------------------
  // message layout
  // ----------------------------------------------------------
  localparam logic [31:0] MAGIC_COOKIE = 32'h6382_5363;
  localparam logic [15:0] DISCOVER_LEN = 16'd244;
  localparam logic [15:0] REQUEST_LEN  = 16'd256;

  localparam logic [8:0] OFS_XID     = 9'd4;
  localparam logic [8:0] OFS_SECS    = 9'd8;
  localparam logic [8:0] OFS_YIADDR  = 9'd16;
  localparam logic [8:0] OFS_CHADDR  = 9'd28;
  localparam logic [8:0] OFS_COOKIE  = 9'd236;
  localparam logic [8:0] OFS_OPTIONS = 9'd240;

  // byte of a big endian field, pos counts from the last byte
  function automatic logic [7:0] field_byte(input logic [47:0] field, input logic [2:0] pos);
    return field[8*pos +: 8];
  endfunction

endpackage

// ==== rtl/dhcp_seconds_timer.sv ====
`timescale 1ns/1ps

module dhcp_seconds_timer #(
  parameter logic [31:0] TICKS_PER_SECOND = 32'd125_000_000,
  parameter logic [3:0]  TIMEOUT_SECONDS  = 4'd4
) (
  input  logic       rx_clock,
  input  logic       rst_n,
  input  logic       timer_restart,
  output logic [3:0] seconds,
  output logic       timeout
);

  logic [31:0] prescale;   // cycles within the current second

  always_ff @(posedge rx_clock) begin
    if (!rst_n) begin
      prescale <= 32'd0;
      seconds  <= 4'd0;
    end else if (timer_restart) begin   // new attempt starts from zero
      prescale <= 32'd0;
      seconds  <= 4'd0;
    end else if (prescale == TICKS_PER_SECOND - 32'd1) begin
      prescale <= 32'd0;
      if (seconds != 4'hf)             // saturate at 15
        seconds <= seconds + 4'd1;
    end else begin
      prescale <= prescale + 32'd1;
    end
  end

  // level, held until the next restart
  assign timeout = (seconds >= TIMEOUT_SECONDS);

endmodule

// ==== rtl/dhcp_client_fsm.sv ====
`timescale 1ns/1ps

module dhcp_client_fsm import dhcp_pkg::*; #(
  parameter logic [3:0] MAX_RETRIES = 4'd4
) (
  input  logic rx_clock,
  input  logic rst_n,
  input  logic start,
  input  logic offer_seen,
  input  logic ack_seen,
  input  logic nak_seen,
  input  logic tx_done,
  input  logic timeout,
  output logic send_discover,
  output logic send_request,
  output logic timer_restart,
  output logic dhcp_success,
  output logic dhcp_failed
);

  dhcp_state_t state;
  logic [3:0]  attempts;     // transmissions in the current phase
  logic        retry_left;

  assign retry_left = (attempts < MAX_RETRIES);

  // secs and timeout both count from the last transmission
  assign timer_restart = start | tx_done;

  always_ff @(posedge rx_clock) begin
    if (!rst_n) begin
      state         <= ST_IDLE;
      attempts      <= 4'd0;
      send_discover <= 1'b0;
      send_request  <= 1'b0;
      dhcp_success  <= 1'b0;
      dhcp_failed   <= 1'b0;
    end else begin
      send_discover <= 1'b0;
      send_request  <= 1'b0;
      if (start) begin             // restart from any state, results cleared
        state         <= ST_DISCOVER;
        attempts      <= 4'd1;
        send_discover <= 1'b1;
        dhcp_success  <= 1'b0;
        dhcp_failed   <= 1'b0;
      end else begin
        case (state)
          ST_DISCOVER: if (tx_done) state <= ST_WAIT_OFFER;
          ST_REQUEST:  if (tx_done) state <= ST_WAIT_ACK;
          ST_WAIT_OFFER: begin
            if (offer_seen) begin
              state        <= ST_REQUEST;
              attempts     <= 4'd1;    // request phase has its own budget
              send_request <= 1'b1;
            end else if (timeout && retry_left) begin
              state         <= ST_DISCOVER;
              attempts      <= attempts + 4'd1;
              send_discover <= 1'b1;
            end else if (timeout) begin
              state       <= ST_FAILED;
              dhcp_failed <= 1'b1;
            end
          end
          ST_WAIT_ACK: begin
            if (ack_seen) begin
              state        <= ST_BOUND;
              dhcp_success <= 1'b1;
            end else if (nak_seen) begin
              state       <= ST_FAILED;
              dhcp_failed <= 1'b1;
            end else if (timeout && retry_left) begin
              state        <= ST_REQUEST;
              attempts     <= attempts + 4'd1;
              send_request <= 1'b1;
            end else if (timeout) begin
              state       <= ST_FAILED;
              dhcp_failed <= 1'b1;
            end
          end
          default: ;                 // idle, bound and failed wait for start
        endcase
      end
    end
  end

endmodule

// ==== rtl/dhcp_tx_builder.sv ====
`timescale 1ns/1ps

module dhcp_tx_builder import dhcp_pkg::*; (
  input  logic        rx_clock,
  input  logic        rst_n,
  input  logic        send_discover,
  input  logic        send_request,
  input  logic        udp_tx_enable,
  input  logic        udp_tx_active,
  input  logic [47:0] local_mac,
  input  logic [3:0]  seconds,
  input  logic [31:0] offered_ip,
  input  logic [31:0] server_ip,
  output logic        dhcp_tx_request,
  output logic [7:0]  tx_data,
  output logic [15:0] length,
  output logic        tx_done,
  output logic [31:0] xid,
  output logic [31:0] ip_accept
);

  typedef enum logic [1:0] {TX_IDLE, TX_PENDING, TX_SEND} tx_state_t;

  tx_state_t   tx_state;
  logic [15:0] xid_count;    // free running until the first discover
  logic        xid_frozen;
  logic        is_request;   // message type of the pending message
  logic [8:0]  byte_no;      // index of the next byte to load
  logic [7:0]  next_byte;

  assign xid = {local_mac[15:0], xid_count};

  always_ff @(posedge rx_clock) begin
    if (!rst_n) begin
      xid_count  <= 16'd0;
      xid_frozen <= 1'b0;
    end else if (send_discover) begin
      xid_frozen <= 1'b1;        // keep the same xid for every retry
    end else if (!xid_frozen) begin
      xid_count <= xid_count + 16'd1;
    end
  end

  // ----------------------------------------------------------
  // byte at index byte_no
  // ----------------------------------------------------------
  always_comb begin
    case (byte_no) inside
      9'd0, 9'd1: next_byte = 8'h01;        // op BOOTREQUEST, htype ethernet
      9'd2:       next_byte = 8'h06;        // hlen
      [OFS_XID : OFS_XID + 9'd3]:
        next_byte = field_byte({16'd0, xid}, 3'(OFS_XID + 9'd3 - byte_no));
      OFS_SECS + 9'd1: next_byte = {4'd0, seconds};
      [OFS_CHADDR : OFS_CHADDR + 9'd5]:
        next_byte = field_byte(local_mac, 3'(OFS_CHADDR + 9'd5 - byte_no));
      [OFS_COOKIE : OFS_COOKIE + 9'd3]:
        next_byte = field_byte({16'd0, MAGIC_COOKIE}, 3'(OFS_COOKIE + 9'd3 - byte_no));
      OFS_OPTIONS:          next_byte = OPT_MSG_TYPE;
      OFS_OPTIONS + 9'd1:   next_byte = 8'd1;
      OFS_OPTIONS + 9'd2:   next_byte = is_request ? MSG_REQUEST : MSG_DISCOVER;
      OFS_OPTIONS + 9'd3:   next_byte = is_request ? OPT_REQ_IP : OPT_END;  // discover ends here
      OFS_OPTIONS + 9'd4:   next_byte = 8'd4;
      [OFS_OPTIONS + 9'd5 : OFS_OPTIONS + 9'd8]:
        next_byte = field_byte({16'd0, ip_accept}, 3'(OFS_OPTIONS + 9'd8 - byte_no));
      OFS_OPTIONS + 9'd9:   next_byte = OPT_SERVER_ID;
      OFS_OPTIONS + 9'd10:  next_byte = 8'd4;
      [OFS_OPTIONS + 9'd11 : OFS_OPTIONS + 9'd14]:
        next_byte = field_byte({16'd0, server_ip}, 3'(OFS_OPTIONS + 9'd14 - byte_no));
      OFS_OPTIONS + 9'd15:  next_byte = OPT_END;
      default:              next_byte = 8'h00;   // hops, flags, addresses, sname, file
    endcase
  end

  // ----------------------------------------------------------
  // request, grant and byte stream
  // ----------------------------------------------------------
  always_ff @(posedge rx_clock) begin
    if (!rst_n) begin
      tx_state        <= TX_IDLE;
      dhcp_tx_request <= 1'b0;
      tx_done         <= 1'b0;
      byte_no         <= 9'd0;
      ip_accept       <= 32'd0;
    end else begin
      tx_done <= 1'b0;
      case (tx_state)
        TX_IDLE: begin
          byte_no <= 9'd0;
          if (send_discover || send_request) begin
            is_request      <= send_request;
            length          <= send_request ? REQUEST_LEN : DISCOVER_LEN;
            dhcp_tx_request <= 1'b1;
            tx_state        <= TX_PENDING;
            if (send_request)
              ip_accept <= offered_ip;      // address we ask for
          end
        end
        TX_PENDING: begin
          if (udp_tx_enable) begin          // byte 0 goes out with the grant
            tx_data  <= next_byte;
            byte_no  <= 9'd1;
            tx_state <= TX_SEND;
          end
        end
        TX_SEND: begin
          if (udp_tx_active) begin          // byte on tx_data consumed
            if ({7'd0, byte_no} == length) begin
              dhcp_tx_request <= 1'b0;
              tx_done         <= 1'b1;
              tx_state        <= TX_IDLE;
            end else begin
              tx_data <= next_byte;
              byte_no <= byte_no + 9'd1;
            end
          end
        end
        default: tx_state <= TX_IDLE;
      endcase
    end
  end

endmodule

// ==== rtl/dhcp_rx_parser.sv ====
`timescale 1ns/1ps

module dhcp_rx_parser import dhcp_pkg::*; (
  input  logic        rx_clock,
  input  logic        rst_n,
  input  logic [7:0]  rx_data,
  input  logic        rx_enable,
  input  logic        dhcp_rx_active,
  input  logic [31:0] xid,
  input  logic [47:0] local_mac,
  output logic        offer_seen,
  output logic        ack_seen,
  output logic        nak_seen,
  output logic [31:0] offered_ip,
  output logic [31:0] lease,
  output logic [31:0] server_ip
);

  typedef enum logic [2:0] {
    RX_IDLE,    // expect op
    RX_FIXED,   // fixed header up to the cookie
    RX_CODE,
    RX_LEN,
    RX_DATA,
    RX_DONE     // wait for end of packet
  } rx_state_t;

  rx_state_t   rx_state;
  logic [8:0]  rx_byte_no;
  logic [7:0]  opt_code;
  logic [7:0]  opt_left;     // option bytes still to come
  logic [7:0]  msg_type;
  logic [31:0] yiaddr_tmp;
  logic [31:0] lease_tmp;
  logic [31:0] server_tmp;
  logic [7:0]  expect_byte;
  logic        mismatch;

  // ----------------------------------------------------------
  // checked header fields
  // ----------------------------------------------------------
  always_comb begin
    case (rx_byte_no) inside
      [OFS_XID : OFS_XID + 9'd3]:
        expect_byte = field_byte({16'd0, xid}, 3'(OFS_XID + 9'd3 - rx_byte_no));
      [OFS_CHADDR : OFS_CHADDR + 9'd5]:
        expect_byte = field_byte(local_mac, 3'(OFS_CHADDR + 9'd5 - rx_byte_no));
      [OFS_COOKIE : OFS_COOKIE + 9'd3]:
        expect_byte = field_byte({16'd0, MAGIC_COOKIE}, 3'(OFS_COOKIE + 9'd3 - rx_byte_no));
      default: expect_byte = rx_data;      // not checked
    endcase
  end

  assign mismatch = (expect_byte != rx_data);

  always_ff @(posedge rx_clock) begin
    if (!rst_n) begin
      rx_state   <= RX_IDLE;
      rx_byte_no <= 9'd0;
      offer_seen <= 1'b0;
      ack_seen   <= 1'b0;
      nak_seen   <= 1'b0;
      offered_ip <= 32'd0;
      lease      <= 32'd0;
      server_ip  <= 32'd0;
    end else begin
      offer_seen <= 1'b0;
      ack_seen   <= 1'b0;
      nak_seen   <= 1'b0;
      if (!dhcp_rx_active) begin
        rx_state <= RX_IDLE;             // packet over
      end else if (rx_enable) begin
        case (rx_state)
          RX_IDLE: begin
            rx_byte_no <= 9'd1;
            msg_type   <= 8'd0;
            lease_tmp  <= 32'd0;
            server_tmp <= 32'd0;
            rx_state   <= (rx_data == 8'h02) ? RX_FIXED : RX_DONE;   // BOOTREPLY only
          end
          RX_FIXED: begin
            rx_byte_no <= rx_byte_no + 9'd1;
            if (rx_byte_no inside {[OFS_YIADDR : OFS_YIADDR + 9'd3]})
              yiaddr_tmp <= {yiaddr_tmp[23:0], rx_data};
            if (mismatch)
              rx_state <= RX_DONE;           // not ours
            else if (rx_byte_no == OFS_OPTIONS - 9'd1)
              rx_state <= RX_CODE;
          end
          RX_CODE: begin
            opt_code <= rx_data;
            if (rx_data == OPT_END) begin
              rx_state   <= RX_DONE;
              offer_seen <= (msg_type == MSG_OFFER);
              ack_seen   <= (msg_type == MSG_ACK);
              if (msg_type == MSG_OFFER || msg_type == MSG_ACK) begin
                offered_ip <= yiaddr_tmp;
                lease      <= lease_tmp;
                server_ip  <= server_tmp;
              end
            end else if (rx_data != OPT_PAD) begin
              rx_state <= RX_LEN;            // pad has no length byte
            end
          end
          RX_LEN: begin
            opt_left <= rx_data;
            rx_state <= (rx_data == 8'd0) ? RX_CODE : RX_DATA;
          end
          RX_DATA: begin
            opt_left <= opt_left - 8'd1;
            if (opt_left == 8'd1)
              rx_state <= RX_CODE;
            case (opt_code)
              OPT_MSG_TYPE: begin
                msg_type <= rx_data;
                if (rx_data == MSG_NAK) begin
                  nak_seen <= 1'b1;          // no need to read further
                  rx_state <= RX_DONE;
                end
              end
              OPT_LEASE:     lease_tmp  <= {lease_tmp[23:0], rx_data};
              OPT_SERVER_ID: server_tmp <= {server_tmp[23:0], rx_data};
              default: ;                     // unknown option skipped by length
            endcase
          end
          default: ;                         // RX_DONE holds until active drops
        endcase
      end
    end
  end

endmodule

// ==== rtl/dhcp_client.sv ====
`timescale 1ns/1ps

module dhcp_client #(
  parameter logic [31:0] TICKS_PER_SECOND = 32'd125_000_000,
  parameter logic [3:0]  TIMEOUT_SECONDS  = 4'd4,
  parameter logic [3:0]  MAX_RETRIES      = 4'd4
) (
  input  logic        rx_clock,
  input  logic        rst_n,
  input  logic        start,
  input  logic [7:0]  rx_data,
  input  logic        rx_enable,
  input  logic        dhcp_rx_active,
  input  logic        udp_tx_enable,
  input  logic        udp_tx_active,
  input  logic [47:0] local_mac,
  output logic        dhcp_tx_request,
  output logic [7:0]  tx_data,
  output logic [15:0] length,
  output logic [31:0] ip_accept,
  output logic [31:0] lease,
  output logic [31:0] server_ip,
  output logic        dhcp_success,
  output logic        dhcp_failed
);

  // ----------------------------------------------------------
  // internal wiring
  // ----------------------------------------------------------
  logic        timer_restart;
  logic [3:0]  seconds;
  logic        timeout;
  logic        send_discover;
  logic        send_request;
  logic        tx_done;
  logic [31:0] xid;
  logic        offer_seen;
  logic        ack_seen;
  logic        nak_seen;
  logic [31:0] offered_ip;

  dhcp_seconds_timer #(
    .TICKS_PER_SECOND(TICKS_PER_SECOND),
    .TIMEOUT_SECONDS (TIMEOUT_SECONDS)
  ) timer_inst (
    .rx_clock     (rx_clock),
    .rst_n        (rst_n),
    .timer_restart(timer_restart),
    .seconds      (seconds),
    .timeout      (timeout)
  );

  dhcp_client_fsm #(
    .MAX_RETRIES(MAX_RETRIES)
  ) fsm_inst (
    .rx_clock     (rx_clock),
    .rst_n        (rst_n),
    .start        (start),
    .offer_seen   (offer_seen),
    .ack_seen     (ack_seen),
    .nak_seen     (nak_seen),
    .tx_done      (tx_done),
    .timeout      (timeout),
    .send_discover(send_discover),
    .send_request (send_request),
    .timer_restart(timer_restart),
    .dhcp_success (dhcp_success),
    .dhcp_failed  (dhcp_failed)
  );

  dhcp_tx_builder builder_inst (
    .rx_clock       (rx_clock),
    .rst_n          (rst_n),
    .send_discover  (send_discover),
    .send_request   (send_request),
    .udp_tx_enable  (udp_tx_enable),
    .udp_tx_active  (udp_tx_active),
    .local_mac      (local_mac),
    .seconds        (seconds),
    .offered_ip     (offered_ip),
    .server_ip      (server_ip),
    .dhcp_tx_request(dhcp_tx_request),
    .tx_data        (tx_data),
    .length         (length),
    .tx_done        (tx_done),
    .xid            (xid),
    .ip_accept      (ip_accept)
  );

  dhcp_rx_parser parser_inst (
    .rx_clock      (rx_clock),
    .rst_n         (rst_n),
    .rx_data       (rx_data),
    .rx_enable     (rx_enable),
    .dhcp_rx_active(dhcp_rx_active),
    .xid           (xid),
    .local_mac     (local_mac),
    .offer_seen    (offer_seen),
    .ack_seen      (ack_seen),
    .nak_seen      (nak_seen),
    .offered_ip    (offered_ip),
    .lease         (lease),
    .server_ip     (server_ip)
  );

endmodule

// ==== tb/dhcp_tb_model.svh ====
`ifndef DHCP_TB_MODEL_SVH
`define DHCP_TB_MODEL_SVH

typedef logic [7:0] pkt_t [0:299];

// byte n of a 32 bit word, n = 0 is the most significant
function automatic logic [7:0] word_byte(input logic [31:0] w, input int n);
  return w[31 - 8*n -: 8];
endfunction

// ------------------------------------------------------------
// expected discover or request, secs taken as given
// ------------------------------------------------------------
function automatic void build_client_msg(input bit is_req, input logic [31:0] xid_v,
                                         input logic [47:0] mac, input logic [7:0] secs,
                                         input logic [31:0] ip, input logic [31:0] srv,
                                         output pkt_t p, output int len);
  int i;
  for (i = 0; i < 300; i++)
    p[i] = 8'h00;
  p[0] = 8'h01;                                  // BOOTREQUEST
  p[1] = 8'h01;                                  // ethernet
  p[2] = 8'h06;
  for (i = 0; i < 4; i++) begin
    p[4 + i]   = word_byte(xid_v, i);
    p[236 + i] = word_byte(32'h6382_5363, i);    // magic cookie
  end
  p[9] = secs;
  for (i = 0; i < 6; i++)
    p[28 + i] = mac[47 - 8*i -: 8];
  p[240] = 8'd53;
  p[241] = 8'd1;
  if (is_req) begin
    p[242] = 8'd3;
    p[243] = 8'd50;                              // requested address
    p[244] = 8'd4;
    p[249] = 8'd54;                              // server identifier
    p[250] = 8'd4;
    for (i = 0; i < 4; i++) begin
      p[245 + i] = word_byte(ip, i);
      p[251 + i] = word_byte(srv, i);
    end
    p[255] = 8'd255;
    len = 256;
  end else begin
    p[242] = 8'd1;
    p[243] = 8'd255;
    len = 244;
  end
endfunction

// server reply; extras adds a pad and an unknown option before lease
function automatic void build_reply(input logic [7:0] mtype, input logic [31:0] xid_v,
                                    input logic [47:0] mac, input logic [31:0] yi,
                                    input logic [31:0] lease_v, input logic [31:0] srv,
                                    input bit extras, output pkt_t p, output int len);
  int i;
  int k;
  for (i = 0; i < 300; i++)
    p[i] = 8'h00;
  p[0] = 8'h02;                                  // BOOTREPLY
  p[1] = 8'h01;
  p[2] = 8'h06;
  for (i = 0; i < 4; i++) begin
    p[4 + i]   = word_byte(xid_v, i);
    p[16 + i]  = word_byte(yi, i);
    p[236 + i] = word_byte(32'h6382_5363, i);
  end
  for (i = 0; i < 6; i++)
    p[28 + i] = mac[47 - 8*i -: 8];
  p[240] = 8'd53;
  p[241] = 8'd1;
  p[242] = mtype;
  k = 243;
  if (extras) begin
    p[k]     = 8'd0;                             // pad
    p[k + 1] = 8'd12;                            // host name, skipped by length
    p[k + 2] = 8'd3;
    p[k + 3] = 8'h61;
    p[k + 4] = 8'h62;
    p[k + 5] = 8'h63;
    k = k + 6;
  end
  p[k]     = 8'd51;
  p[k + 1] = 8'd4;
  p[k + 6] = 8'd54;
  p[k + 7] = 8'd4;
  for (i = 0; i < 4; i++) begin
    p[k + 2 + i] = word_byte(lease_v, i);
    p[k + 8 + i] = word_byte(srv, i);
  end
  p[k + 12] = 8'd255;
  len = k + 13;
endfunction

`endif

// ==== tb/dhcp_client_tb.sv ====
`timescale 1ns/1ps

module dhcp_client_tb;

  `include "dhcp_tb_model.svh"

  localparam int SEC_TICKS       = 20;              // clock cycles per second of the DUT
  localparam int MSG_CYCLES      = 2 * 256 + 100;   // one message with gaps and grant wait
  localparam int TIMEOUT_CYCLES  = SEC_TICKS * 3;
  localparam int WATCHDOG_CYCLES = 7 * MSG_CYCLES + 8 * TIMEOUT_CYCLES + 2000;

  logic        rx_clock = 1'b0;
  logic        rst_n = 1'b0;
  logic        start = 1'b0;
  logic [7:0]  rx_data = 8'h00;
  logic        rx_enable = 1'b0;
  logic        dhcp_rx_active = 1'b0;
  logic        udp_tx_enable = 1'b0;
  logic        udp_tx_active = 1'b0;
  logic [47:0] local_mac = 48'h02_1a_2b_3c_4d_5e;
  logic        dhcp_tx_request;
  logic [7:0]  tx_data;
  logic [15:0] length;
  logic [31:0] ip_accept;
  logic [31:0] lease;
  logic [31:0] server_ip;
  logic        dhcp_success;
  logic        dhcp_failed;

  // server side capture of client messages
  logic [7:0]  msg_mem [0:15][0:299];
  int          msg_len [0:15];
  logic [15:0] msg_adv [0:15];      // length port at the grant
  logic [7:0]  msg_secs [0:15];     // secs the client should have sent
  int          msg_count = 0;
  int          cur_count = 0;
  int          srv_state = 0;
  int          wait_left = 0;
  int          stall_cycles = 0;
  int          checked = 0;

  logic [15:0] cycle_count = 16'd0; // cycles since reset, as the xid count runs
  int          tick = 0;            // cycles since the last start or end of message
  logic [31:0] xid_exp = 32'd0;     // low mac bytes, then the count at the first discover

  logic [31:0] req_ip = 32'd0;      // address and server a request should carry
  logic [31:0] req_srv = 32'd0;
  int          errors = 0;
  int          checks = 0;
  int          byte_errors = 0;

  dhcp_client #(
    .TICKS_PER_SECOND(SEC_TICKS),
    .TIMEOUT_SECONDS (4'd3),
    .MAX_RETRIES     (4'd2)
  ) dhcp_client_inst (
    .rx_clock(rx_clock), .rst_n(rst_n), .start(start),
    .rx_data(rx_data), .rx_enable(rx_enable), .dhcp_rx_active(dhcp_rx_active),
    .udp_tx_enable(udp_tx_enable), .udp_tx_active(udp_tx_active),
    .local_mac(local_mac), .dhcp_tx_request(dhcp_tx_request), .tx_data(tx_data),
    .length(length), .ip_accept(ip_accept), .lease(lease), .server_ip(server_ip),
    .dhcp_success(dhcp_success), .dhcp_failed(dhcp_failed)
  );

  always #50 rx_clock = ~rx_clock;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    $display("test %s: %s", name, (errors == err_before) ? "ok" : "errors");
  endtask

  // whole seconds after t cycles, saturating like the 4 bit secs count
  function automatic logic [7:0] secs_at(input int t);
    return (t / SEC_TICKS > 15) ? 8'd15 : 8'(t / SEC_TICKS);
  endfunction

  // ------------------------------------------------------------
  // time since reset and since the last timer restart
  // ------------------------------------------------------------
  always @(posedge rx_clock) begin
    if (!rst_n) begin
      cycle_count <= 16'd0;
      tick        <= 0;
    end else begin
      cycle_count <= cycle_count + 16'd1;
      if (start || (srv_state == 3 && !dhcp_tx_request))   // start or tx_done
        tick <= 0;
      else
        tick <= tick + 1;
    end
  end

  // ------------------------------------------------------------
  // packet layer: grant after a random wait, random active gaps
  // ------------------------------------------------------------
  always @(posedge rx_clock) begin
    if (!rst_n) begin
      srv_state     <= 0;
      udp_tx_enable <= 1'b0;
      udp_tx_active <= 1'b0;
    end else begin
      case (srv_state)
        0: if (dhcp_tx_request && msg_count < 16) begin
          wait_left          <= int'($urandom_range(0, 7));
          msg_adv[msg_count] <= length;
          cur_count          <= 0;
          srv_state          <= 1;
        end
        1: if (wait_left == 0) begin
          udp_tx_enable <= 1'b1;                   // one cycle grant
          srv_state     <= 2;
        end else begin
          wait_left <= wait_left - 1;
        end
        2: begin
          udp_tx_enable <= 1'b0;
          udp_tx_active <= ($urandom_range(0, 1) == 1);
          srv_state     <= 3;
        end
        default: begin
          if (!dhcp_tx_request) begin              // message over
            udp_tx_active      <= 1'b0;
            msg_len[msg_count] <= cur_count;
            msg_count          <= msg_count + 1;
            cur_count          <= 0;
            srv_state          <= 0;
          end else begin
            if (udp_tx_active && cur_count < 300) begin
              msg_mem[msg_count][cur_count] <= tx_data;
              if (cur_count == 8)
                msg_secs[msg_count] <= secs_at(tick);   // secs byte loads as byte 8 goes
              cur_count <= cur_count + 1;
            end else if (!udp_tx_active) begin
              stall_cycles <= stall_cycles + 1;
            end
            udp_tx_active <= ($urandom_range(0, 1) == 1);
          end
        end
      endcase
    end
  end

  // ------------------------------------------------------------
  // compare each finished message with the reference
  // ------------------------------------------------------------
  task automatic compare_message(input int i);
    pkt_t        exp;
    int          exp_len;
    int          j;
    int          e;
    e = errors;
    build_client_msg(msg_adv[i] == 16'd256, xid_exp, local_mac, msg_secs[i],
                     req_ip, req_srv, exp, exp_len);
    check_value($sformatf("length of message %0d", i), {16'd0, msg_adv[i]}, exp_len);
    check_value($sformatf("bytes sent in message %0d", i), msg_len[i], exp_len);
    for (j = 0; j < exp_len && j < msg_len[i]; j++)
      check_value($sformatf("tx_data byte %0d of message %0d", j, i),
                  {24'd0, msg_mem[i][j]}, {24'd0, exp[j]});
    byte_errors += errors - e;
  endtask

  always @(posedge rx_clock) begin
    if (rst_n && msg_count > checked) begin
      compare_message(checked);
      checked <= checked + 1;
    end
  end

  // stream a reply; bytes from hold_at on wait until hold_msgs messages are sent
  task automatic send_reply(input pkt_t p, input int len, input int hold_at,
                            input int hold_msgs);
    int i;
    for (i = 0; i < len; i++) begin
      if (i == hold_at) begin
        @(posedge rx_clock);
        rx_enable <= 1'b0;                         // packet stays open
        while (msg_count < hold_msgs)
          @(posedge rx_clock);
      end
      @(posedge rx_clock);
      rx_data        <= p[i];
      rx_enable      <= 1'b1;
      dhcp_rx_active <= 1'b1;
    end
    @(posedge rx_clock);
    rx_enable      <= 1'b0;
    dhcp_rx_active <= 1'b0;
    @(posedge rx_clock);
  endtask

  task automatic pulse_start();
    @(posedge rx_clock);
    start <= 1'b1;
    @(posedge rx_clock);
    start <= 1'b0;
  endtask

  // until message k is on the wire with its xid already sent
  task automatic wait_xid_sent(input int k);
    while (!(msg_count == k && cur_count >= 8))
      @(posedge rx_clock);
  endtask

  task automatic wait_checked(input int k);
    while (checked < k)
      @(posedge rx_clock);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * 100);
    $display("watchdog expired before the tests completed");
    $display("TESTS FAILED");
    $finish;
  end

  // ------------------------------------------------------------
  // tests
  // ------------------------------------------------------------
  initial begin
    int          seed_val;
    int          e0;
    int          plen;
    pkt_t        pkt;
    logic [31:0] xid_v;
    seed_val = int'($urandom(85));
    req_ip  = 32'hc0a8_0164;                       // 192.168.1.100
    req_srv = 32'hc0a8_0101;
    repeat (4) @(posedge rx_clock);
    rst_n <= 1'b1;
    @(negedge rx_clock);
    check_value("dhcp_tx_request after reset", {31'd0, dhcp_tx_request}, 0);
    check_value("dhcp_success after reset", {31'd0, dhcp_success}, 0);
    check_value("dhcp_failed after reset", {31'd0, dhcp_failed}, 0);
    check_value("ip_accept after reset", ip_accept, 0);
    check_value("lease after reset", lease, 0);
    check_value("server_ip after reset", server_ip, 0);

    // discover, request rises 2 cycles after start
    e0 = errors;
    pulse_start();
    @(negedge rx_clock);
    xid_exp = {local_mac[15:0], cycle_count};      // send_discover is high in this cycle
    check_value("dhcp_tx_request one cycle after start", {31'd0, dhcp_tx_request}, 0);
    @(negedge rx_clock);
    check_value("dhcp_tx_request two cycles after start", {31'd0, dhcp_tx_request}, 1);
    wait_xid_sent(0);
    xid_v = xid_exp;
    check_value("xid of discover",
                {msg_mem[0][4], msg_mem[0][5], msg_mem[0][6], msg_mem[0][7]}, xid_v);

    // two offers that are not ours, both on the wire during the discover
    build_reply(8'd2, xid_v ^ 32'h1, local_mac, req_ip, 32'd600, req_srv, 1'b0, pkt, plen);
    send_reply(pkt, plen, plen, 0);
    build_reply(8'd2, xid_v, local_mac ^ 48'h1, req_ip, 32'd600, req_srv, 1'b0, pkt, plen);
    send_reply(pkt, plen, plen - 1, 1);
    wait_checked(1);
    check_value("message type of discover", {24'd0, msg_mem[0][242]}, 1);
    report_test("discover", e0);

    // good offer, its END only after the retried discover is out
    e0 = errors;
    build_reply(8'd2, xid_v, local_mac, req_ip, 32'd600, req_srv, 1'b0, pkt, plen);
    send_reply(pkt, plen, plen - 1, 2);
    check_value("length of second message", {16'd0, msg_adv[1]}, 244);
    check_value("secs of retried discover is nonzero", {31'd0, msg_mem[1][9] != 8'd0}, 1);
    report_test("rejected offers", e0);

    e0 = errors;
    while (!dhcp_tx_request)
      @(posedge rx_clock);
    build_reply(8'd5, xid_v, local_mac, req_ip, 32'd86400, req_srv, 1'b1, pkt, plen);
    send_reply(pkt, plen, plen - 1, 3);
    wait_checked(3);
    check_value("length of request", {16'd0, msg_adv[2]}, 256);
    check_value("ip_accept", ip_accept, req_ip);
    report_test("request", e0);

    e0 = errors;
    while (!dhcp_success)
      @(posedge rx_clock);
    check_value("lease", lease, 32'd86400);
    check_value("server_ip", server_ip, req_srv);
    check_value("dhcp_failed when bound", {31'd0, dhcp_failed}, 0);
    report_test("acknowledge", e0);

    // new exchange, other server and address, answered by a nak
    e0 = errors;
    req_ip  = 32'h0a00_002a;
    req_srv = 32'h0a00_0001;
    pulse_start();
    wait_xid_sent(3);
    build_reply(8'd2, xid_v, local_mac, req_ip, 32'd300, req_srv, 1'b0, pkt, plen);
    send_reply(pkt, plen, plen - 1, 4);
    while (!dhcp_tx_request)
      @(posedge rx_clock);
    build_reply(8'd6, xid_v, local_mac, 32'd0, 32'd0, req_srv, 1'b0, pkt, plen);
    send_reply(pkt, plen, 242, 5);                 // type byte after the request
    while (!dhcp_failed)
      @(posedge rx_clock);
    check_value("dhcp_success after nak", {31'd0, dhcp_success}, 0);
    // no replies at all
    pulse_start();
    @(negedge rx_clock);
    check_value("dhcp_failed cleared by start", {31'd0, dhcp_failed}, 0);
    while (!dhcp_failed)
      @(posedge rx_clock);
    repeat (100) @(posedge rx_clock);
    check_value("messages sent", msg_count, 7);
    check_value("length of message 5", {16'd0, msg_adv[5]}, 244);
    check_value("length of message 6", {16'd0, msg_adv[6]}, 244);
    report_test("failure", e0);

    e0 = errors;
    wait_checked(msg_count);
    check_value("stall cycles seen", {31'd0, stall_cycles > 0}, 1);
    check_value("byte mismatches", byte_errors, 0);
    report_test("back-pressure", e0);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+tb
rtl/dhcp_pkg.sv
rtl/dhcp_seconds_timer.sv
rtl/dhcp_client_fsm.sv
rtl/dhcp_tx_builder.sv
rtl/dhcp_rx_parser.sv
rtl/dhcp_client.sv
tb/dhcp_client_tb.sv

// ==== Makefile ====
.PHONY: compile run clean

compile:
	verilator --binary --timing -f sources.f --top-module dhcp_client_tb -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/Vdhcp_client_tb); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir
